/* design/fp_format_pkg.sv */
// binary32 only; subnormals are not flushed and are treated as ordinary finite values
package fp_format_pkg;

    // ======================================================================
    // field layout
    // ======================================================================
    localparam int flt_w    = 32;       // whole float
    localparam int exp_w    = 8;        // biased exponent
    localparam int man_w    = 23;       // stored fraction, hidden bit not included
    localparam int exp_bias = 127;

    localparam logic [exp_w-1:0] exp_max = '1;     // inf and nan exponent

    // ======================================================================
    // special encodings
    // ======================================================================
    localparam logic [flt_w-1:0] qnan_default = 32'h7FC0_0000;  // canonical quiet nan
    localparam logic [flt_w-1:0] one_pos      = 32'h3F80_0000;  // +1.0
    localparam logic [flt_w-1:0] one_neg      = 32'hBF80_0000;  // -1.0

    // integer saturation limits for float to int
    localparam logic [flt_w-1:0] int_max_pos = 32'h7FFF_FFFF;
    localparam logic [flt_w-1:0] int_min_neg = 32'h8000_0000;

endpackage

/* design/fp_op_pkg.sv */
// opcode and flag encodings; the status word is flt_w wide, so fp_format_pkg compiles first
package fp_op_pkg;

    // ======================================================================
    // operations
    // ======================================================================
    typedef enum logic [3:0] {
        op_fmov  = 4'h0,    // move
        op_fneg  = 4'h1,    // negate
        op_fabs  = 4'h2,    // absolute value
        op_fnabs = 4'h3,    // negative absolute value
        op_fsign = 4'h4,    // get sign as +-1.0
        op_fman  = 4'h5,    // get mantissa
        op_fcmp  = 4'h6,    // compare
        op_ftoi  = 4'h7,    // float to int, truncating
        op_itof  = 4'h8,    // int to float, truncating
        op_ftx   = 4'h9,    // trigger exception
        op_fcx   = 4'hA,    // clear exception
        op_fex   = 4'hB,    // enable exception
        op_fdx   = 4'hC,    // disable exception
        op_fstat = 4'hD     // read status word
    } fp_op_e;

    // exception flag positions, shared by flags, enables and imm masks
    localparam int n_flags = 3;
    typedef enum logic [1:0] {
        flag_invalid = 2'd0,
        flag_inexact = 2'd1,
        flag_swt     = 2'd2     // software triggered
    } flag_idx_e;

    // bit positions of a compare result
    typedef enum logic [1:0] {
        cmp_eq = 2'd0,
        cmp_lt = 2'd1,
        cmp_le = 2'd2,
        cmp_un = 2'd3           // unordered, a nan was seen
    } cmp_bit_e;

    // status word: flags low, enables at bit 4, rest zero
    localparam int stat_flag_lsb = 0;
    localparam int stat_en_lsb   = 4;

    function automatic logic [fp_format_pkg::flt_w-1:0] status_word(
        input logic [n_flags-1:0] flags,
        input logic [n_flags-1:0] enables
    );
        logic [fp_format_pkg::flt_w-1:0] w;
        w = '0;
        w[stat_flag_lsb +: n_flags] = flags;
        w[stat_en_lsb   +: n_flags] = enables;
        return w;
    endfunction

endpackage

/* design/fp_unpack_stage.sv */
// pipeline stage 1; zero means exponent and fraction both zero, subnormals are not flushed
module fp_unpack_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_i,   // one-cycle strobe
    input  fp_op_pkg::fp_op_e                 op_i,
    input  logic [fp_format_pkg::flt_w-1:0]   a_i,
    input  logic [fp_format_pkg::flt_w-1:0]   b_i,
    input  logic [fp_op_pkg::n_flags-1:0]     imm_i,     // status mask
    output logic                              valid_o,
    output fp_op_pkg::fp_op_e                 op_o,
    output logic [fp_format_pkg::flt_w-1:0]   a_o,
    output logic [fp_format_pkg::flt_w-1:0]   b_o,
    output logic [fp_op_pkg::n_flags-1:0]     imm_o,
    output logic                              a_sign_o,
    output logic [fp_format_pkg::exp_w-1:0]   a_exp_o,
    output logic [fp_format_pkg::man_w-1:0]   a_frac_o,
    output logic                              a_zero_o,
    output logic                              a_inf_o,
    output logic                              a_nan_o,
    output logic                              b_zero_o,
    output logic                              b_nan_o
);
    import fp_format_pkg::*;

    logic [exp_w-1:0] a_exp, b_exp;
    logic [man_w-1:0] a_frac, b_frac;

    // field split
    assign a_exp  = a_i[flt_w-2 -: exp_w];
    assign a_frac = a_i[man_w-1:0];
    assign b_exp  = b_i[flt_w-2 -: exp_w];
    assign b_frac = b_i[man_w-1:0];

    // strobe is the only control state here
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= start_i;
        end
    end

    // payload and class bits, loaded every cycle
    always_ff @(posedge clk) begin
        op_o     <= op_i;
        a_o      <= a_i;
        b_o      <= b_i;
        imm_o    <= imm_i;
        a_sign_o <= a_i[flt_w-1];
        a_exp_o  <= a_exp;
        a_frac_o <= a_frac;
        a_zero_o <= (a_exp == '0) && (a_frac == '0);
        a_inf_o  <= (a_exp == exp_max) && (a_frac == '0);
        a_nan_o  <= (a_exp == exp_max) && (a_frac != '0);
        b_zero_o <= (b_exp == '0) && (b_frac == '0);     // compare needs b class only
        b_nan_o  <= (b_exp == exp_max) && (b_frac != '0);
    end

endmodule

/* design/fp_exec_stage.sv */
// pipeline stage 2; conversions truncate toward zero, unknown opcodes return the default qnan
module fp_exec_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_i,
    input  fp_op_pkg::fp_op_e                 op_i,
    input  logic [fp_format_pkg::flt_w-1:0]   a_i,
    input  logic [fp_format_pkg::flt_w-1:0]   b_i,
    input  logic [fp_op_pkg::n_flags-1:0]     imm_i,
    input  logic                              a_sign_i,
    input  logic [fp_format_pkg::exp_w-1:0]   a_exp_i,
    input  logic [fp_format_pkg::man_w-1:0]   a_frac_i,
    input  logic                              a_zero_i,
    input  logic                              a_inf_i,
    input  logic                              a_nan_i,
    input  logic                              b_zero_i,
    input  logic                              b_nan_i,
    output logic                              valid_o,
    output fp_op_pkg::fp_op_e                 op_o,
    output logic [fp_op_pkg::n_flags-1:0]     imm_o,
    output logic [fp_format_pkg::flt_w-1:0]   result_o,
    output logic [fp_op_pkg::n_flags-1:0]     raise_o
);
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    logic [flt_w-1:0]   res_nxt;
    logic [n_flags-1:0] raise_nxt;

    // compare terms
    logic [flt_w-2:0] mag_a, mag_b;
    logic             cmp_eq_v, cmp_lt_v;

    // float to int
    logic [54:0]      ftoi_w;       // mantissa scaled, 23 fraction bits below the point
    logic [exp_w-1:0] ftoi_sh;      // unbiased exponent
    logic [flt_w-1:0] ftoi_mag;

    // int to float
    logic [flt_w-1:0] itof_mag, itof_norm;
    logic [4:0]       itof_lead;    // position of the leading one

    // ======================================================================
    // datapath helpers
    // ======================================================================
    assign mag_a    = {a_exp_i, a_frac_i};
    assign mag_b    = b_i[flt_w-2:0];
    assign cmp_eq_v = (a_zero_i && b_zero_i) || (a_i == b_i);    // +0 == -0
    assign cmp_lt_v = (a_zero_i && b_zero_i) ? 1'b0 :
                      (a_sign_i != b_i[flt_w-1]) ? a_sign_i :   // negative one is smaller
                      a_sign_i ? (mag_a > mag_b) : (mag_a < mag_b);

    assign ftoi_sh  = a_exp_i - exp_w'(exp_bias);
    assign ftoi_w   = {31'b0, 1'b1, a_frac_i} << ftoi_sh[4:0];  // only used for exp 127..157
    assign ftoi_mag = ftoi_w[54:23];

    assign itof_mag  = a_i[flt_w-1] ? (~a_i + 1'b1) : a_i;      // -2^31 maps onto itself
    assign itof_norm = itof_mag << (5'd31 - itof_lead);         // leading one to bit 31

    always_comb begin
        itof_lead = '0;
        for (int i = 0; i < flt_w; i++) begin
            if (itof_mag[i]) itof_lead = 5'(i);
        end
    end

    // ======================================================================
    // per-operation result and raised flags
    // ======================================================================
    always_comb begin
        res_nxt   = '0;
        raise_nxt = '0;
        case (op_i)
            op_fmov:  res_nxt = a_i;
            op_fneg:  res_nxt = {~a_sign_i, mag_a};
            op_fabs:  res_nxt = {1'b0, mag_a};
            op_fnabs: res_nxt = {1'b1, mag_a};
            op_fsign: res_nxt = (a_zero_i || a_nan_i) ? a_i : (a_sign_i ? one_neg : one_pos);
            op_fman:  res_nxt = flt_w'({(a_exp_i != '0), a_frac_i});   // hidden bit if normal
            op_fcmp: begin
                if (a_nan_i || b_nan_i) begin
                    res_nxt[cmp_un]          = 1'b1;    // unordered alone
                    raise_nxt[flag_invalid]  = 1'b1;
                end else begin
                    res_nxt[cmp_eq] = cmp_eq_v;
                    res_nxt[cmp_lt] = cmp_lt_v;
                    res_nxt[cmp_le] = cmp_lt_v | cmp_eq_v;
                end
            end
            op_ftoi: begin
                if (a_nan_i) begin
                    res_nxt                 = int_max_pos;
                    raise_nxt[flag_invalid] = 1'b1;
                end else if (a_inf_i || a_exp_i >= exp_w'(exp_bias + 31)) begin
                    res_nxt = a_sign_i ? int_min_neg : int_max_pos;
                    // exactly -2^31 fits
                    raise_nxt[flag_invalid] = !(a_sign_i && a_exp_i == exp_w'(exp_bias + 31)
                                                && a_frac_i == '0);
                end else if (a_exp_i < exp_w'(exp_bias)) begin
                    res_nxt                 = '0;       // |a| < 1
                    raise_nxt[flag_inexact] = !a_zero_i;
                end else begin
                    res_nxt                 = a_sign_i ? (~ftoi_mag + 1'b1) : ftoi_mag;
                    raise_nxt[flag_inexact] = |ftoi_w[22:0];
                end
            end
            op_itof: begin
                if (itof_mag != '0) begin
                    res_nxt = {a_i[flt_w-1], exp_w'(exp_bias) + exp_w'(itof_lead),
                               itof_norm[flt_w-2 -: man_w]};
                    raise_nxt[flag_inexact] = |itof_norm[7:0];   // bits below the fraction
                end
            end
            op_ftx, op_fcx, op_fex, op_fdx, op_fstat: res_nxt = '0;   // handled in stage 3
            default: res_nxt = qnan_default;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        op_o     <= op_i;
        imm_o    <= imm_i;
        result_o <= res_nxt;
        raise_o  <= raise_nxt;
    end

endmodule

/* design/fp_status_stage.sv */
// pipeline stage 3; fstat returns the state before the reading operation, flags are sticky
module fp_status_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_i,
    input  fp_op_pkg::fp_op_e                 op_i,
    input  logic [fp_op_pkg::n_flags-1:0]     imm_i,
    input  logic [fp_format_pkg::flt_w-1:0]   result_i,
    input  logic [fp_op_pkg::n_flags-1:0]     raise_i,
    output logic                              valid_o,
    output logic [fp_format_pkg::flt_w-1:0]   result_o,
    output logic [fp_op_pkg::n_flags-1:0]     flags_o,     // sticky flags
    output logic                              exception_o
);
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    logic [n_flags-1:0] en_q;               // exception enables
    logic [n_flags-1:0] flags_nxt, en_nxt;
    logic [flt_w-1:0]   result_nxt;

    // ======================================================================
    // next sticky state
    // ======================================================================
    always_comb begin
        flags_nxt  = flags_o;               // hold unless an op arrives
        en_nxt     = en_q;
        result_nxt = result_i;              // stage 2 already zeroes status ops
        if (valid_i) begin
            flags_nxt = flags_o | raise_i;
            case (op_i)
                op_ftx: begin
                    flags_nxt           = flags_nxt | imm_i;
                    flags_nxt[flag_swt] = 1'b1;
                end
                op_fcx:   flags_nxt  = flags_nxt & ~imm_i;
                op_fex:   en_nxt     = en_q | imm_i;
                op_fdx:   en_nxt     = en_q & ~imm_i;
                op_fstat: result_nxt = status_word(flags_o, en_q);   // old state
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o     <= 1'b0;
            result_o    <= '0;
            flags_o     <= '0;
            en_q        <= '0;
            exception_o <= 1'b0;
        end else begin
            valid_o     <= valid_i;
            flags_o     <= flags_nxt;
            en_q        <= en_nxt;
            exception_o <= |(flags_nxt & en_nxt);   // enabled and set
            if (valid_i) result_o <= result_nxt;    // hold between ops
        end
    end

endmodule

/* design/fp_unit.sv */
// binary32 unit, three cycle latency, one op per cycle, no back-pressure on start_i
module fp_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_i,
    input  fp_op_pkg::fp_op_e                 op_i,
    input  logic [fp_format_pkg::flt_w-1:0]   a_i,
    input  logic [fp_format_pkg::flt_w-1:0]   b_i,
    input  logic [fp_op_pkg::n_flags-1:0]     imm_i,
    output logic                              valid_o,
    output logic [fp_format_pkg::flt_w-1:0]   result_o,
    output logic [fp_op_pkg::n_flags-1:0]     flags_o,
    output logic                              exception_o
);
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    // ======================================================================
    // stage 1 to stage 2
    // ======================================================================
    logic               u_valid;
    fp_op_e             u_op;
    logic [flt_w-1:0]   u_a, u_b;
    logic [n_flags-1:0] u_imm;
    logic               u_a_sign, u_a_zero, u_a_inf, u_a_nan;
    logic [exp_w-1:0]   u_a_exp;
    logic [man_w-1:0]   u_a_frac;
    logic               u_b_zero, u_b_nan;

    // stage 2 to stage 3
    logic               x_valid;
    fp_op_e             x_op;
    logic [n_flags-1:0] x_imm, x_raise;
    logic [flt_w-1:0]   x_result;

    fp_unpack_stage unpack_i (
        .clk(clk), .rst(rst), .start_i(start_i), .op_i(op_i),
        .a_i(a_i), .b_i(b_i), .imm_i(imm_i),
        .valid_o(u_valid), .op_o(u_op), .a_o(u_a), .b_o(u_b), .imm_o(u_imm),
        .a_sign_o(u_a_sign), .a_exp_o(u_a_exp), .a_frac_o(u_a_frac),
        .a_zero_o(u_a_zero), .a_inf_o(u_a_inf), .a_nan_o(u_a_nan),
        .b_zero_o(u_b_zero), .b_nan_o(u_b_nan)
    );

    fp_exec_stage exec_i (
        .clk(clk), .rst(rst), .valid_i(u_valid), .op_i(u_op),
        .a_i(u_a), .b_i(u_b), .imm_i(u_imm),
        .a_sign_i(u_a_sign), .a_exp_i(u_a_exp), .a_frac_i(u_a_frac),
        .a_zero_i(u_a_zero), .a_inf_i(u_a_inf), .a_nan_i(u_a_nan),
        .b_zero_i(u_b_zero), .b_nan_i(u_b_nan),
        .valid_o(x_valid), .op_o(x_op), .imm_o(x_imm),
        .result_o(x_result), .raise_o(x_raise)
    );

    fp_status_stage status_i (
        .clk(clk), .rst(rst), .valid_i(x_valid), .op_i(x_op), .imm_i(x_imm),
        .result_i(x_result), .raise_i(x_raise),
        .valid_o(valid_o), .result_o(result_o), .flags_o(flags_o),
        .exception_o(exception_o)
    );

endmodule

/* test/fp_unit_tb.sv */
// directed tests for fp_unit; expects three cycle latency and a sticky status model kept here
module fp_unit_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    localparam int clk_period = 100;
    localparam int n_ops      = 131;    // operations issued by all tests together
    localparam int valid_wait = 8;      // cycles allowed before valid_o is declared missing

    logic               clk, rst, start;
    fp_op_e             op_in;
    logic [flt_w-1:0]   a_in, b_in, result;
    logic [n_flags-1:0] imm_in, flags;
    logic               valid, exc;

    logic [n_flags-1:0] model_flags, model_en;   // expected sticky state
    logic [31:0]        lfsr_state;
    int                 errors;

    fp_unit fp_unit_i (
        .clk(clk), .rst(rst), .start_i(start), .op_i(op_in), .a_i(a_in), .b_i(b_in),
        .imm_i(imm_in), .valid_o(valid), .result_o(result), .flags_o(flags),
        .exception_o(exc)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ======================================================================
    // stimulus helpers and checks
    // ======================================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);   // galois, right shifting
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w          = {w[30:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [flt_w-1:0] cmp_pattern(input logic eq, lt, un);
        logic [flt_w-1:0] r;
        r         = '0;
        r[cmp_eq] = eq;
        r[cmp_lt] = lt;
        r[cmp_le] = eq | lt;
        r[cmp_un] = un;
        return r;
    endfunction

    task automatic check_result(input string what, input logic [flt_w-1:0] got, want);
        if (got !== want) begin
            errors++;
            $display("[ERROR] result_o (%s): got %h, expected %h", what, got, want);
        end
    endtask

    task automatic check_flags(input string what, input logic [n_flags-1:0] got, want);
        if (got !== want) begin
            errors++;
            $display("[ERROR] flags_o (%s): got %h, expected %h", what, got, want);
        end
    endtask

    task automatic check_exception(input string what, input logic got, want);
        if (got !== want) begin
            errors++;
            $display("[ERROR] exception_o (%s): got %h, expected %h", what, got, want);
        end
    endtask

    // one strobe, then wait for valid_o with a bound
    task automatic issue_op(input fp_op_e op, input logic [flt_w-1:0] a, b,
                            input logic [n_flags-1:0] imm, output logic seen);
        @(negedge clk);
        start  = 1'b1;
        op_in  = op;
        a_in   = a;
        b_in   = b;
        imm_in = imm;
        @(negedge clk);
        start = 1'b0;
        seen  = 1'b0;
        for (int i = 0; i < valid_wait && !seen; i++) begin
            @(negedge clk);
            seen = valid;
        end
    endtask

    // runs one op, advances the status model and checks all three outputs
    task automatic run_and_check(input string what, input fp_op_e op,
                                 input logic [flt_w-1:0] a, b, input logic [n_flags-1:0] imm,
                                 input logic [flt_w-1:0] exp_res,
                                 input logic [n_flags-1:0] exp_raise);
        logic [flt_w-1:0] want;
        logic             seen;
        want = exp_res;
        if (op == op_fstat) begin
            want      = '0;             // word of the state before the read
            want[2:0] = model_flags;
            want[6:4] = model_en;
        end
        model_flags = model_flags | exp_raise;
        case (op)
            op_ftx: model_flags = model_flags | imm | (1 << flag_swt);
            op_fcx: model_flags = model_flags & ~imm;
            op_fex: model_en    = model_en | imm;
            op_fdx: model_en    = model_en & ~imm;
            default: ;
        endcase
        issue_op(op, a, b, imm, seen);
        if (!seen) begin
            errors++;
            $display("valid_o never came for %s within %0d cycles", what, valid_wait);
        end else begin
            check_result(what, result, want);
            check_flags(what, flags, model_flags);
            check_exception(what, exc, |(model_flags & model_en));
        end
    endtask

    // ======================================================================
    // tests
    // ======================================================================
    task automatic sign_ops();
        logic [flt_w-1:0] a, sgn;
        logic             special;
        for (int n = 0; n < 16; n++) begin
            rand_word(a);
            special = (a[30:0] == '0) || (a[30:23] == 8'hFF && a[22:0] != '0);
            sgn     = special ? a : (a[31] ? one_neg : one_pos);
            run_and_check("fmov", op_fmov, a, '0, '0, a, '0);
            run_and_check("fneg", op_fneg, a, '0, '0, a ^ 32'h8000_0000, '0);
            run_and_check("fabs", op_fabs, a, '0, '0, a & 32'h7FFF_FFFF, '0);
            run_and_check("fnabs", op_fnabs, a, '0, '0, a | 32'h8000_0000, '0);
            run_and_check("fsign", op_fsign, a, '0, '0, sgn, '0);
            run_and_check("fman", op_fman, a, '0, '0, {8'h00, a[30:23] != '0, a[22:0]}, '0);
        end
        // zero and nan pass through get-sign unchanged
        run_and_check("fsign +0", op_fsign, 32'h0000_0000, '0, '0, 32'h0000_0000, '0);
        run_and_check("fsign -0", op_fsign, 32'h8000_0000, '0, '0, 32'h8000_0000, '0);
        run_and_check("fsign nan", op_fsign, 32'hFFC0_0001, '0, '0, 32'hFFC0_0001, '0);
    endtask

    task automatic compare_pairs();
        run_and_check("clear", op_fcx, '0, '0, 3'b111, '0, '0);
        run_and_check("1<2", op_fcmp, 32'h3F80_0000, 32'h4000_0000, '0, cmp_pattern(0, 1, 0), '0);
        run_and_check("2=2", op_fcmp, 32'h4000_0000, 32'h4000_0000, '0, cmp_pattern(1, 0, 0), '0);
        run_and_check("2>1", op_fcmp, 32'h4000_0000, 32'h3F80_0000, '0, cmp_pattern(0, 0, 0), '0);
        run_and_check("+0=-0", op_fcmp, 32'h0000_0000, 32'h8000_0000, '0, cmp_pattern(1, 0, 0), '0);
        run_and_check("-0=+0", op_fcmp, 32'h8000_0000, 32'h0000_0000, '0,
                      cmp_pattern(1, 0, 0), '0);   // signs differ, still not less
        run_and_check("-inf<+inf", op_fcmp, 32'hFF80_0000, 32'h7F80_0000, '0,
                      cmp_pattern(0, 1, 0), '0);
        run_and_check("-2<-1", op_fcmp, 32'hC000_0000, 32'hBF80_0000, '0, cmp_pattern(0, 1, 0), '0);
        run_and_check("nan", op_fcmp, 32'h7FC0_0000, 32'h3F80_0000, '0, cmp_pattern(0, 0, 1),
                      3'b001);   // invalid
        run_and_check("nan b", op_fcmp, 32'h3F80_0000, 32'h7FC0_0000, '0, cmp_pattern(0, 0, 1),
                      3'b001);   // nan on the second operand
    endtask

    task automatic conversions();
        run_and_check("clear", op_fcx, '0, '0, 3'b111, '0, '0);
        run_and_check("ftoi 2.5", op_ftoi, 32'h4020_0000, '0, '0, 32'd2, 3'b010);
        run_and_check("ftoi -2.5", op_ftoi, 32'hC020_0000, '0, '0, 32'hFFFF_FFFE, 3'b010);
        run_and_check("ftoi 1e10", op_ftoi, 32'h5015_02F9, '0, '0, 32'h7FFF_FFFF, 3'b001);
        run_and_check("ftoi -2^31", op_ftoi, 32'hCF00_0000, '0, '0, 32'h8000_0000, '0);
        run_and_check("ftoi nan", op_ftoi, 32'h7FC0_0000, '0, '0, 32'h7FFF_FFFF, 3'b001);
        run_and_check("itof 5", op_itof, 32'd5, '0, '0, 32'h40A0_0000, '0);
        run_and_check("itof -3", op_itof, 32'hFFFF_FFFD, '0, '0, 32'hC040_0000, '0);
        run_and_check("itof 0", op_itof, 32'd0, '0, '0, 32'h0000_0000, '0);
        run_and_check("itof 2^24+1", op_itof, 32'h0100_0001, '0, '0, 32'h4B80_0000, 3'b010);
    endtask

    task automatic status_ops();
        run_and_check("fcx all", op_fcx, '0, '0, 3'b111, '0, '0);
        run_and_check("ftx", op_ftx, '0, '0, 3'b001, '0, '0);      // invalid plus swt
        run_and_check("fstat", op_fstat, '0, '0, '0, '0, '0);
        run_and_check("fex inexact", op_fex, '0, '0, 3'b010, '0, '0);   // flag not set, no exc
        run_and_check("fex invalid", op_fex, '0, '0, 3'b001, '0, '0);
        run_and_check("fstat en", op_fstat, '0, '0, '0, '0, '0);
        run_and_check("fdx invalid", op_fdx, '0, '0, 3'b001, '0, '0);
        run_and_check("fcx", op_fcx, '0, '0, 3'b101, '0, '0);
        run_and_check("fdx all", op_fdx, '0, '0, 3'b111, '0, '0);
    endtask

    // three strobes in a row, each result lands exactly three cycles later
    task automatic back_to_back();
        logic [flt_w-1:0] src [3];
        src[0] = 32'h3F80_0000;
        src[1] = 32'hC120_0000;
        src[2] = 32'h4049_0FDB;
        for (int c = 0; c < 7; c++) begin
            @(negedge clk);
            if (c < 3) begin
                start = 1'b1;
                op_in = op_fneg;
                a_in  = src[c];
            end else begin
                start = 1'b0;
            end
            if (c >= 3 && c < 6) begin
                if (!valid) begin
                    errors++;
                    $display("valid_o missing for back-to-back op %0d", c - 3);
                end
                check_result("back-to-back", result, src[c-3] ^ 32'h8000_0000);
            end else if (valid) begin
                errors++;
                $display("valid_o high in cycle %0d of the back-to-back run", c);
            end
        end
    endtask

    // ======================================================================
    // run
    // ======================================================================
    initial begin
        #((n_ops + 10) * 4 * clk_period);
        $display("watchdog expired, the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        op_in       = op_fmov;
        a_in        = '0;
        b_in        = '0;
        imm_in      = '0;
        model_flags = '0;
        model_en    = '0;
        lfsr_state  = 32'd77;
        errors      = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (valid !== 1'b0 || flags !== '0 || exc !== 1'b0 || result !== '0) begin
            errors++;
            $display("outputs not cleared by reset");
        end
        sign_ops();
        compare_pairs();
        conversions();
        status_ops();
        back_to_back();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
design/fp_format_pkg.sv
design/fp_op_pkg.sv
design/fp_unpack_stage.sv
design/fp_exec_stage.sv
design/fp_status_stage.sv
design/fp_unit.sv
test/fp_unit_tb.sv

/* Bender.yml */
package:
  name: fp_unit

sources:
  - design/fp_format_pkg.sv
  - design/fp_op_pkg.sv
  - design/fp_unpack_stage.sv
  - design/fp_exec_stage.sv
  - design/fp_status_stage.sv
  - design/fp_unit.sv
  - target: test
    files:
      - test/fp_unit_tb.sv
